/* rtl/exti_pkg.sv */
package exti_pkg;

    // bus word and address
    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;

    // level picks one of the four cpu lines
    typedef logic [1:0] level_t;
    typedef logic [3:0] cpu_int_t;

    // gpio pin vector
    typedef logic [7:0] pins_t;

    // interrupt sources seen by the controller
    localparam int num_sources = 2;
    // bit position in enable and pending
    // level field sits at 2*index
    localparam int src_gpio  = 0;
    localparam int src_timer = 1;

    // gpio block
    // gpio_in is read only
    localparam addr_t gpio_in_addr  = 16'hFF00;
    localparam addr_t gpio_out_addr = 16'hFF01;
    localparam addr_t gpio_ien_addr = 16'hFF02;

    // timer block
    // cnt is read only, ctl bit 0 is run
    localparam addr_t timer_cmp_addr = 16'hFF08;
    localparam addr_t timer_cnt_addr = 16'hFF09;
    localparam addr_t timer_ctl_addr = 16'hFF0A;

    // interrupt controller
    // pending reads back, write one to clear
    localparam addr_t exti_en_addr    = 16'hFF0C;
    localparam addr_t exti_level_addr = 16'hFF0D;
    localparam addr_t exti_pend_addr  = 16'hFF0E;

endpackage

/* rtl/rw_register.sv */
`timescale 1ns/1ps

module rw_register #(
    parameter exti_pkg::addr_t reg_addr      = 16'h0000,
    parameter exti_pkg::word_t default_value = 16'h0000
) (
    input  logic            clk,
    input  logic            rst_n,
    // system bus
    input  exti_pkg::addr_t addr,
    input  logic            write_en,
    input  exti_pkg::word_t data_in,
    output exti_pkg::word_t data_out,
    // stored word for the owning block
    output exti_pkg::word_t value
);

    logic hit;

    // address decode for this one register
    assign hit = (addr == reg_addr);

    // load on a matching write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value <= default_value;
        end else if (write_en && hit) begin
            value <= data_in;
        end
    end

    // zero off-address so the parent can OR
    always_comb begin
        if (hit) begin
            data_out = value;
        end else begin
            data_out = '0;
        end
    end

endmodule

/* rtl/gpio.sv */
`timescale 1ns/1ps

module gpio (
    input  logic            clk,
    input  logic            rst_n,
    // system bus
    input  exti_pkg::addr_t addr,
    input  logic            write_en,
    input  exti_pkg::word_t data_in,
    output exti_pkg::word_t data_out,
    // pins
    input  exti_pkg::pins_t pins,
    output exti_pkg::pins_t gpio_out,
    // rising edge interrupt pulse
    output logic            gpio_int
);

    import exti_pkg::*;

    word_t out_rdata;
    word_t out_value;
    word_t ien_rdata;
    word_t ien_value;
    word_t in_rdata;
    pins_t pins_q;
    pins_t pins_prev;
    pins_t pin_rise;

    // output latch, low byte drives the pins
    rw_register #(
        .reg_addr     (gpio_out_addr),
        .default_value(16'h0000)
    ) out_reg_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (addr),
        .write_en(write_en),
        .data_in (data_in),
        .data_out(out_rdata),
        .value   (out_value)
    );

    // per-pin interrupt enable
    rw_register #(
        .reg_addr     (gpio_ien_addr),
        .default_value(16'h0000)
    ) ien_reg_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (addr),
        .write_en(write_en),
        .data_in (data_in),
        .data_out(ien_rdata),
        .value   (ien_value)
    );

    assign gpio_out = out_value[7:0];

    // edge between two samples on an enabled pin
    assign pin_rise = pins_q & ~pins_prev & ien_value[7:0];

    // sample, keep the previous sample, register the pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pins_q    <= '0;
            pins_prev <= '0;
            gpio_int  <= 1'b0;
        end else begin
            pins_q    <= pins;
            pins_prev <= pins_q;
            gpio_int  <= |pin_rise;
        end
    end

    // read side returns sampled pins
    assign in_rdata = (addr == gpio_in_addr) ? word_t'(pins_q) : '0;

    assign data_out = in_rdata | out_rdata | ien_rdata;

endmodule

/* rtl/timer.sv */
`timescale 1ns/1ps

module timer (
    input  logic            clk,
    input  logic            rst_n,
    // system bus
    input  exti_pkg::addr_t addr,
    input  logic            write_en,
    input  exti_pkg::word_t data_in,
    output exti_pkg::word_t data_out,
    // match pulse
    output logic            timer_int
);

    import exti_pkg::*;

    word_t cmp_rdata;
    word_t cmp_value;
    word_t ctl_rdata;
    word_t ctl_value;
    word_t cnt_rdata;
    word_t cnt;
    logic  run;

    // compare value
    rw_register #(
        .reg_addr     (timer_cmp_addr),
        .default_value(16'h0000)
    ) cmp_reg_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (addr),
        .write_en(write_en),
        .data_in (data_in),
        .data_out(cmp_rdata),
        .value   (cmp_value)
    );

    // control, bit 0 starts the count
    rw_register #(
        .reg_addr     (timer_ctl_addr),
        .default_value(16'h0000)
    ) ctl_reg_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (addr),
        .write_en(write_en),
        .data_in (data_in),
        .data_out(ctl_rdata),
        .value   (ctl_value)
    );

    assign run = ctl_value[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt       <= '0;
            timer_int <= 1'b0;
        end else if (run) begin
            // wrap on match, also if compare was lowered below the count
            if (cnt >= cmp_value) begin
                cnt       <= '0;
                timer_int <= 1'b1;
            end else begin
                cnt       <= cnt + 16'd1;
                timer_int <= 1'b0;
            end
        end else begin
            // stopped, count holds
            timer_int <= 1'b0;
        end
    end

    // live count is read only
    assign cnt_rdata = (addr == timer_cnt_addr) ? cnt : '0;

    assign data_out = cmp_rdata | ctl_rdata | cnt_rdata;

endmodule

/* rtl/exti.sv */
`timescale 1ns/1ps

module exti (
    input  logic               clk,
    input  logic               rst_n,
    // system bus
    input  exti_pkg::addr_t    addr,
    input  logic               write_en,
    input  exti_pkg::word_t    data_in,
    output exti_pkg::word_t    data_out,
    // interrupt pulses from the peripherals
    input  logic               gpio_int,
    input  logic               timer_int,
    // lines to the cpu
    output exti_pkg::cpu_int_t cpu_int
);

    import exti_pkg::*;

    word_t en_rdata;
    word_t en_value;
    word_t level_rdata;
    word_t level_value;
    word_t pend_rdata;

    logic [num_sources-1:0] src;
    logic [num_sources-1:0] src_prev;
    logic [num_sources-1:0] src_rise;
    logic [num_sources-1:0] pending;
    logic [num_sources-1:0] pend_clr;
    logic [num_sources-1:0] active;
    level_t                 src_level [num_sources];

    // enable register, one bit per source
    rw_register #(
        .reg_addr     (exti_en_addr),
        .default_value(16'h0000)
    ) en_reg_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (addr),
        .write_en(write_en),
        .data_in (data_in),
        .data_out(en_rdata),
        .value   (en_value)
    );

    // level register, two bits per source
    rw_register #(
        .reg_addr     (exti_level_addr),
        .default_value(16'h0000)
    ) level_reg_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (addr),
        .write_en(write_en),
        .data_in (data_in),
        .data_out(level_rdata),
        .value   (level_value)
    );

    // gather sources by their index
    always_comb begin
        src            = '0;
        src[src_gpio]  = gpio_int;
        src[src_timer] = timer_int;
    end

    // low then high sets pending
    assign src_rise = src & ~src_prev;

    // write one to clear, only on the pending address
    assign pend_clr = (write_en && addr == exti_pend_addr) ?
                      data_in[num_sources-1:0] : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            src_prev <= '0;
            pending  <= '0;
        end else begin
            src_prev <= src;
            // a new edge beats a clear on the same cycle
            pending  <= (pending & ~pend_clr) | src_rise;
        end
    end

    // split the level word into per-source fields
    for (genvar s = 0; s < num_sources; s++) begin : g_level
        assign src_level[s] = level_value[2*s +: 2];
    end

    assign active = pending & en_value[num_sources-1:0];

    // one-hot per source, equal levels share a line
    always_comb begin
        cpu_int = '0;
        for (int i = 0; i < num_sources; i++) begin
            if (active[i]) begin
                cpu_int[src_level[i]] = 1'b1;
            end
        end
    end

    // pending read, zero elsewhere
    assign pend_rdata = (addr == exti_pend_addr) ? word_t'(pending) : '0;

    assign data_out = en_rdata | level_rdata | pend_rdata;

endmodule

/* rtl/periph_top.sv */
`timescale 1ns/1ps

module periph_top (
    input  logic               clk,
    input  logic               rst_n,
    // system bus
    input  exti_pkg::addr_t    addr,
    input  logic               write_en,
    input  exti_pkg::word_t    data_in,
    output exti_pkg::word_t    data_out,
    // gpio pins
    input  exti_pkg::pins_t    pins,
    output exti_pkg::pins_t    gpio_out,
    // cpu interrupt lines
    output exti_pkg::cpu_int_t cpu_int
);

    import exti_pkg::*;

    word_t gpio_rdata;
    word_t timer_rdata;
    word_t exti_rdata;
    logic  gpio_int;
    logic  timer_int;

    gpio gpio_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (addr),
        .write_en(write_en),
        .data_in (data_in),
        .data_out(gpio_rdata),
        .pins    (pins),
        .gpio_out(gpio_out),
        .gpio_int(gpio_int)
    );

    timer timer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (addr),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (timer_rdata),
        .timer_int(timer_int)
    );

    // both pulses land in the controller
    exti exti_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (addr),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (exti_rdata),
        .gpio_int (gpio_int),
        .timer_int(timer_int),
        .cpu_int  (cpu_int)
    );

    // blocks drive zero off their addresses
    // unmapped reads fall out as zero
    assign data_out = gpio_rdata | timer_rdata | exti_rdata;

endmodule

/* sim/tb_periph_top.sv */
`timescale 1ns/1ps

module tb_periph_top;

    import exti_pkg::*;

    logic     clk;
    logic     rst_n;
    addr_t    addr;
    logic     write_en;
    word_t    data_in;
    word_t    data_out;
    pins_t    pins;
    pins_t    gpio_out;
    cpu_int_t cpu_int;

    // model of every register and the pending bits
    word_t m_out   = '0;
    word_t m_ien   = '0;
    word_t m_cmp   = '0;
    word_t m_ctl   = '0;
    word_t m_en    = '0;
    word_t m_level = '0;
    logic [num_sources-1:0] m_pend = '0;
    logic [31:0] lfsr;

    // writable registers for the random pass
    addr_t wr_addrs [6] = '{gpio_out_addr, gpio_ien_addr, timer_cmp_addr,
                            timer_ctl_addr, exti_en_addr, exti_level_addr};

    periph_top dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (addr),
        .write_en(write_en),
        .data_in (data_in),
        .data_out(data_out),
        .pins    (pins),
        .gpio_out(gpio_out),
        .cpu_int (cpu_int)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    // one step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t r;
        logic  fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[14:0], fb};
        end
        return r;
    endfunction

    // each pending and enabled source lights the line its level picks
    function automatic cpu_int_t expected_lines();
        cpu_int_t c;
        c = '0;
        for (int s = 0; s < num_sources; s++) begin
            if (m_pend[s] && m_en[s]) begin
                c[m_level[2*s +: 2]] = 1'b1;
            end
        end
        return c;
    endfunction

    // expected read data per address
    // read-only and unmapped addresses give zero
    function automatic word_t expected_read(input addr_t a);
        case (a)
            gpio_out_addr:   return m_out;
            gpio_ien_addr:   return m_ien;
            timer_cmp_addr:  return m_cmp;
            timer_ctl_addr:  return m_ctl;
            exti_en_addr:    return m_en;
            exti_level_addr: return m_level;
            exti_pend_addr:  return word_t'(m_pend);
            default:         return '0;
        endcase
    endfunction

    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            stop_run();
        end
    endtask

    task automatic check_lines(input string what);
        cpu_int_t exp;
        exp = expected_lines();
        check(cpu_int === exp, $sformatf("cpu_int %b expected %b, %s", cpu_int, exp, what));
    endtask

    // one-cycle write
    // model follows at the same edge
    task automatic bus_write(input addr_t a, input word_t d);
        @(negedge clk);
        addr     = a;
        data_in  = d;
        write_en = 1'b1;
        @(negedge clk);
        write_en = 1'b0;
        case (a)
            gpio_out_addr:   m_out   = d;
            gpio_ien_addr:   m_ien   = d;
            timer_cmp_addr:  m_cmp   = d;
            timer_ctl_addr:  m_ctl   = d;
            exti_en_addr:    m_en    = d;
            exti_level_addr: m_level = d;
            // write one to clear
            exti_pend_addr:  m_pend  = m_pend & ~d[num_sources-1:0];
            default: ;
        endcase
    endtask

    // combinational read sampled mid low phase
    task automatic read_check(input addr_t a, input word_t exp);
        @(negedge clk);
        addr     = a;
        write_en = 1'b0;
        #10;
        check(data_out === exp, $sformatf("read %h got %h expected %h", a, data_out, exp));
    endtask

    task automatic wait_pending(input logic [num_sources-1:0] want, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        addr     = exti_pend_addr;
        write_en = 1'b0;
        #10;
        while (data_out[num_sources-1:0] !== want && n < limit) begin
            @(negedge clk);
            #10;
            n++;
        end
        if (data_out[num_sources-1:0] !== want) begin
            $display("timeout after %0d cycles waiting for pending bits %b", limit, want);
            stop_run();
        end
    endtask

    // raise the chosen sources, check the mapping, then clear
    task automatic fire_sources(input logic use_gpio, input logic use_timer);
        logic [num_sources-1:0] want;
        pins_t                  pin;
        want            = '0;
        want[src_gpio]  = use_gpio;
        want[src_timer] = use_timer;
        if (use_timer) begin
            bus_write(timer_cmp_addr, rand_bits(3));
            bus_write(timer_ctl_addr, 16'h0001);
        end
        if (use_gpio) begin
            // one random pin that is always enabled
            pin = pins_t'(1) << rand_bits(3);
            bus_write(gpio_ien_addr, rand_bits(16) | word_t'(pin));
            @(negedge clk);
            pins = pin;
        end
        m_pend = m_pend | want;
        wait_pending(want, use_timer ? 20 : 3);
        // equal levels share one line when both are enabled
        if (want == 2'b11 && m_en[1:0] == 2'b11) begin
            check($countones(cpu_int) == ((m_level[1:0] == m_level[3:2]) ? 1 : 2),
                  "number of active cpu lines");
        end
        check_lines("sources pending");
        if (use_gpio) begin
            // sampled pins read back on the input address
            read_check(gpio_in_addr, word_t'(pin));
        end
        if (use_timer) begin
            // count never passes compare while running
            for (int k = 0; k < 4; k++) begin
                @(negedge clk);
                addr = timer_cnt_addr;
                #10;
                check(data_out <= m_cmp, $sformatf("count %0d above compare %0d",
                                                   data_out, m_cmp));
            end
            bus_write(timer_ctl_addr, 16'h0000);
        end
        repeat (3) @(negedge clk);
        pins = '0;
        // writing zero leaves pending alone
        bus_write(exti_pend_addr, 16'h0000);
        check_lines("after writing zero to pending");
        read_check(exti_pend_addr, expected_read(exti_pend_addr));
        // clear takes effect at the write edge
        bus_write(exti_pend_addr, word_t'(want));
        check_lines("after clearing pending");
        read_check(exti_pend_addr, expected_read(exti_pend_addr));
    endtask

    initial begin
        addr_t  a;
        level_t lv0;
        level_t lv1;
        lfsr     = 32'he751ca66;
        rst_n    = 1'b0;
        addr     = '0;
        write_en = 1'b0;
        data_in  = '0;
        pins     = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // reset state of the whole block including unmapped holes
        check(cpu_int === '0 && gpio_out === '0, "outputs not zero after reset");
        for (int i = 0; i < 15; i++) begin
            read_check(addr_t'(16'hFF00 + i), 16'h0000);
        end

        // random register traffic
        for (int i = 0; i < 40; i++) begin
            a = wr_addrs[rand_bits(16) % 6];
            bus_write(a, rand_bits(16));
            read_check(a, expected_read(a));
            check(gpio_out === m_out[7:0], "gpio_out does not follow its register");
            a = wr_addrs[rand_bits(16) % 6];
            read_check(a, expected_read(a));
            // FF10 and up wraps past the top and is unmapped
            read_check(addr_t'(16'hFF10 + rand_bits(8)), 16'h0000);
        end
        // random ctl may have started the timer
        bus_write(timer_ctl_addr, 16'h0000);
        repeat (3) @(negedge clk);
        bus_write(exti_pend_addr, 16'hFFFF);
        check_lines("after flushing pending");

        // gpio edges with random enable and level
        for (int i = 0; i < 8; i++) begin
            bus_write(exti_en_addr, rand_bits(16));
            bus_write(exti_level_addr, rand_bits(16));
            fire_sources(1'b1, 1'b0);
        end

        // timer match on a small compare
        for (int i = 0; i < 4; i++) begin
            bus_write(exti_en_addr, rand_bits(16));
            bus_write(exti_level_addr, rand_bits(16));
            fire_sources(1'b0, 1'b1);
        end

        // both sources with alternating equal and different levels
        for (int i = 0; i < 6; i++) begin
            lv0 = level_t'(rand_bits(2));
            lv1 = (i % 2 == 0) ? lv0 : level_t'(lv0 + 1 + rand_bits(1));
            bus_write(exti_en_addr, 16'h0003);
            bus_write(exti_level_addr, word_t'({lv1, lv0}));
            fire_sources(1'b1, 1'b1);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

/* src.f */
rtl/exti_pkg.sv
rtl/rw_register.sv
rtl/gpio.sv
rtl/timer.sv
rtl/exti.sv
rtl/periph_top.sv
sim/tb_periph_top.sv
